/* Makefile */
TOP = backend_tb

all: run

build:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP) -o sim

# the simulation log decides the result, the exit status of the binary is ignored
run: build
	-./obj_dir/sim +verilator+error+limit+100 > run.log 2>&1
	cat run.log
	grep -q "^All checks passed$$" run.log

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

.PHONY: all build run lint clean

/* compile.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/pipe_reg.sv
verilog/execute_stage.sv
verilog/ex_mem.sv
verilog/mem_stage.sv
verilog/backend_top.sv
verification/backend_props.sv
verification/backend_tb.sv

/* verification/backend_props.sv */
`timescale 1ns/10ps

module backend_props import cpu_pkg::*; (
   input logic      clk,
   input logic      arst_n,
   input logic      stall_q_n,        // internal load enable of ex_mem
   input logic      in_take_new_pc,
   input logic      out_stall_n,
   input word_t     out_alu_out,
   input reg_addr_t out_wr_reg
);

   int unsigned fails = 0;   // failure count, summed into the end of run result

   // the first edge after reset release still sees the cleared slot flag
   slot_empty_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !out_stall_n)
      else begin
         $error("out_stall_n high in the first cycle after reset");
         fails++;
      end

   flush_drops_slot: assert property (
      @(posedge clk) disable iff (!arst_n) in_take_new_pc |=> !out_stall_n)
      else begin
         $error("taken transfer did not drop the slot");
         fails++;
      end

   held_fields_stable: assert property (
      @(posedge clk) disable iff (!arst_n)
      !stall_q_n |=> ($stable(out_alu_out) && $stable(out_wr_reg)))
      else begin
         $error("held slot fields changed");
         fails++;
      end

endmodule

bind ex_mem backend_props u_props (
   .clk, .arst_n, .stall_q_n, .in_take_new_pc, .out_stall_n, .out_alu_out, .out_wr_reg
);

/* verification/backend_tb.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module backend_tb import cpu_pkg::*; ();

   localparam int AW         = $clog2(`CPU_DMEM_DEPTH);
   localparam int N_ALU      = 400;
   localparam int N_PAIR     = 40;   // store then load pairs
   localparam int N_STALL    = 200;
   localparam int N_READBACK = 20;
   localparam int N_BRANCH   = 200;
   localparam int MAX_CYCLES = 10 + 4 + N_ALU + 2 * N_PAIR + N_STALL + N_READBACK
                               + N_BRANCH + 16 + 100;

   logic      clk;
   logic      arst_n;
   word_t     rd_data_1, rd_data_2, sext_imm, pc_inc;
   alu_op_t   alu_op;
   logic      alu_src_imm;
   set_sel_t  set_sel;
   logic      branch_en, branch_on_zero, jump_reg;
   logic      mem_en, mem_wr_en;
   reg_addr_t wr_reg;
   wr_sel_t   wr_sel;
   logic      stall_n;
   logic      wb_en;
   reg_addr_t wb_reg;
   word_t     wb_data;
   logic      redirect_en;
   word_t     redirect_pc;

   word_t         mem_model [`CPU_DMEM_DEPTH];
   logic [AW-1:0] written [$];   // addresses that hold a known word
   int            n_checks = 0;
   int            n_errs = 0;
   int            cycles = 0;

   backend_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
   end

   function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
      case (op)
         alu_add: return a + b;
         alu_sub: return a - b;
         alu_and: return a & b;
         alu_or:  return a | b;
         alu_xor: return a ^ b;
         alu_sll: return a << b[3:0];
         alu_srl: return a >> b[3:0];
         default: return b;
      endcase
   endfunction

   function automatic logic set_model(set_sel_t sel, word_t a, word_t b);
      logic [`CPU_DATA_W:0] sum;
      sum = {1'b0, a} + {1'b0, b};
      case (sel)
         set_seq: return a == b;
         set_slt: return $signed(a) < $signed(b);
         set_sle: return $signed(a) <= $signed(b);
         default: return sum[`CPU_DATA_W];   // carry out
      endcase
   endfunction

   function automatic logic cond_holds(logic on_zero, word_t v);
      return on_zero ? (v == '0) : (v != '0);
   endfunction

   task automatic check_word(input string what, input word_t got, input word_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errs++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errs++;
         $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      n_checks++;
      if (got !== exp) begin
         n_errs++;
         $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic idle_inputs();
      rd_data_1      = '0;
      rd_data_2      = '0;
      sext_imm       = '0;
      pc_inc         = '0;
      alu_op         = alu_add;
      alu_src_imm    = 1'b0;
      set_sel        = set_seq;
      branch_en      = 1'b0;
      branch_on_zero = 1'b0;
      jump_reg       = 1'b0;
      mem_en         = 1'b0;
      mem_wr_en      = 1'b0;
      wr_reg         = '0;
      wr_sel         = wb_none;
      stall_n        = 1'b1;
   endtask

   task automatic random_alu_slot();
      idle_inputs();
      rd_data_1   = word_t'($urandom);
      rd_data_2   = word_t'($urandom);
      sext_imm    = word_t'($urandom);
      pc_inc      = word_t'($urandom);
      alu_op      = alu_op_t'($urandom_range(0, 7));
      alu_src_imm = ($urandom_range(0, 1) == 1);
      set_sel     = set_sel_t'($urandom_range(0, 3));
      wr_reg      = reg_addr_t'($urandom);
      case ($urandom_range(0, 3))
         0:       wr_sel = wb_alu;
         1:       wr_sel = wb_set;
         2:       wr_sel = wb_imm;
         default: wr_sel = wb_pc_inc;
      endcase
   endtask

   // address travels through pass_b from the immediate
   task automatic set_store(input logic [AW-1:0] a, input word_t d);
      alu_op            = alu_pass_b;
      alu_src_imm       = 1'b1;
      sext_imm[AW-1:0]  = a;
      rd_data_2         = d;
      mem_en            = 1'b1;
      mem_wr_en         = 1'b1;
      wr_sel            = wb_none;
   endtask

   task automatic set_load(input logic [AW-1:0] a);
      alu_op           = alu_pass_b;
      alu_src_imm      = 1'b1;
      sext_imm[AW-1:0] = a;
      mem_en           = 1'b1;
      mem_wr_en        = 1'b0;
      wr_sel           = wb_mem;
   endtask

   task automatic mixed_slot(input bit stalls, input bit branches);
      int            kind;
      logic [AW-1:0] a;
      random_alu_slot();
      kind = $urandom_range(0, 2);
      if (written.size() > 0 && $urandom_range(0, 1) == 1)
         a = written[$urandom_range(0, written.size() - 1)];   // overwrite a known word
      else
         a = AW'($urandom);
      if (kind == 0)
         set_store(a, word_t'($urandom));
      else if (kind == 1 && written.size() > 0)
         set_load(written[$urandom_range(0, written.size() - 1)]);
      if (stalls)
         stall_n = ($urandom_range(0, 3) != 0);
      if (branches) begin
         branch_en      = ($urandom_range(0, 2) == 0);
         jump_reg       = ($urandom_range(0, 5) == 0);
         branch_on_zero = ($urandom_range(0, 1) == 1);
         if ($urandom_range(0, 3) == 0)
            rd_data_1 = '0;
      end
   endtask

   // predict the slot from the driven inputs, then check it one edge later
   task automatic run_slot();
      word_t b;
      word_t res;
      word_t exp_data;
      word_t target;
      logic  take;
      logic  valid;
      logic  store;
      logic  exp_wb;
      b      = alu_src_imm ? sext_imm : rd_data_2;
      res    = alu_model(alu_op, rd_data_1, b);
      take   = jump_reg | (branch_en & cond_holds(branch_on_zero, rd_data_1));
      target = jump_reg ? rd_data_1 + sext_imm : pc_inc + sext_imm;
      valid  = stall_n & ~take;   // flush beats stall
      store  = valid & mem_en & mem_wr_en;
      case (wr_sel)
         wb_alu:    exp_data = res;
         wb_mem:    exp_data = mem_model[res[AW-1:0]];
         wb_set:    exp_data = word_t'(set_model(set_sel, rd_data_1, b));
         wb_imm:    exp_data = sext_imm;
         wb_pc_inc: exp_data = pc_inc;
         default:   exp_data = '0;
      endcase
      exp_wb = valid & (wr_sel != wb_none);
      @(posedge clk);
      #2;
      check_bit("wb_en", wb_en, exp_wb);
      if (exp_wb) begin
         check_reg("wb_reg", wb_reg, wr_reg);
         check_word("wb_data", wb_data, exp_data);
      end
      check_bit("redirect_en", redirect_en, take);
      if (take)
         check_word("redirect_pc", redirect_pc, target);
      if (store) begin
         mem_model[res[AW-1:0]] = rd_data_2;
         written.push_back(res[AW-1:0]);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %s finished with %0d errors", name, n_errs - errs_before);
   endtask

   initial begin
      int            start;
      int            prop_fails;
      logic [AW-1:0] a;
      void'($urandom(13215));
      arst_n = 1'b0;
      idle_inputs();
      repeat (10) @(posedge clk);
      #2 arst_n = 1'b1;

      start = n_errs;
      check_bit("wb_en after reset", wb_en, 1'b0);
      check_bit("redirect_en after reset", redirect_en, 1'b0);
      set_store(8'h42, 16'hbeef);   // first cycle store
      run_slot();
      set_load(8'h42);
      run_slot();
      idle_inputs();
      run_slot();
      report_test("reset and first store", start);

      start = n_errs;
      repeat (N_ALU) begin
         random_alu_slot();
         run_slot();
      end
      report_test("random alu and set", start);

      start = n_errs;
      repeat (N_PAIR) begin
         random_alu_slot();
         a = AW'($urandom);
         set_store(a, word_t'($urandom));
         run_slot();
         random_alu_slot();
         set_load(a);
         run_slot();
      end
      report_test("store then load", start);

      start = n_errs;
      repeat (N_STALL) begin
         mixed_slot(1'b1, 1'b0);
         run_slot();
      end
      repeat (N_READBACK) begin
         random_alu_slot();
         set_load(written[$urandom_range(0, written.size() - 1)]);
         run_slot();
      end
      report_test("random stalls", start);

      start = n_errs;
      repeat (N_BRANCH) begin
         mixed_slot(1'b0, 1'b1);
         run_slot();
      end
      report_test("branches and jumps", start);

      start = n_errs;
      random_alu_slot();
      wr_sel = wb_alu;
      run_slot();
      idle_inputs();
      #10 arst_n = 1'b0;   // between edges
      #1 check_bit("wb_en in reset", wb_en, 1'b0);
      repeat (3) @(posedge clk);
      #2 arst_n = 1'b1;
      run_slot();
      repeat (10) begin
         random_alu_slot();
         run_slot();
      end
      report_test("reset mid-run", start);

      prop_fails = DUT.u_ex_mem.u_props.fails;
      $display("%0d checks, %0d errors, %0d assertion failures", n_checks, n_errs, prop_fails);
      if (n_errs == 0 && prop_fails == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

/* verilog/backend_top.sv */
`timescale 1ns/10ps

module backend_top import cpu_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  word_t     rd_data_1,
   input  word_t     rd_data_2,
   input  word_t     sext_imm,
   input  word_t     pc_inc,
   input  alu_op_t   alu_op,
   input  logic      alu_src_imm,
   input  set_sel_t  set_sel,
   input  logic      branch_en,
   input  logic      branch_on_zero,
   input  logic      jump_reg,
   input  logic      mem_en,
   input  logic      mem_wr_en,
   input  reg_addr_t wr_reg,
   input  wr_sel_t   wr_sel,
   input  logic      stall_n,
   output logic      wb_en,
   output reg_addr_t wb_reg,
   output word_t     wb_data,
   output logic      redirect_en,
   output word_t     redirect_pc
);

   // execute outputs
   word_t ex_alu_out;
   word_t ex_pc_sext_imm;
   word_t ex_reg_sext_imm;
   logic  ex_alu_ofl;
   logic  ex_alu_zero;
   logic  ex_alu_ltz;
   logic  ex_alu_lteq;
   logic  ex_pc_src;
   logic  ex_take_new_pc;

   // ex_mem outputs
   word_t     m_rd_data_2;
   word_t     m_alu_out;
   word_t     m_sext_imm;
   word_t     m_pc_sext_imm;
   word_t     m_reg_sext_imm;
   word_t     m_pc_inc;
   logic      m_alu_ofl;
   logic      m_alu_zero;
   logic      m_alu_ltz;
   logic      m_alu_lteq;
   logic      m_pc_src;
   set_sel_t  m_set_sel;
   logic      m_mem_wr_en;
   logic      m_mem_en;
   reg_addr_t m_wr_reg;
   wr_sel_t   m_wr_sel;
   logic      m_stall_n;
   logic      m_take_new_pc;

   execute_stage u_execute (
      .rd_data_1, .rd_data_2, .sext_imm, .pc_inc, .alu_op, .alu_src_imm, .set_sel,
      .branch_en, .branch_on_zero, .jump_reg,
      .alu_out(ex_alu_out), .pc_sext_imm(ex_pc_sext_imm), .reg_sext_imm(ex_reg_sext_imm),
      .alu_ofl(ex_alu_ofl), .alu_zero(ex_alu_zero), .alu_ltz(ex_alu_ltz),
      .alu_lteq(ex_alu_lteq), .pc_src(ex_pc_src), .take_new_pc(ex_take_new_pc)
   );

   ex_mem u_ex_mem (
      .clk, .arst_n,
      .in_rd_data_2(rd_data_2), .in_alu_out(ex_alu_out), .in_sext_imm(sext_imm),
      .in_pc_sext_imm(ex_pc_sext_imm), .in_reg_sext_imm(ex_reg_sext_imm),
      .in_pc_inc(pc_inc), .in_alu_ofl(ex_alu_ofl), .in_alu_zero(ex_alu_zero),
      .in_alu_ltz(ex_alu_ltz), .in_alu_lteq(ex_alu_lteq), .in_pc_src(ex_pc_src),
      .in_set_sel(set_sel), .in_mem_wr_en(mem_wr_en), .in_mem_en(mem_en),
      .in_wr_reg(wr_reg), .in_wr_sel(wr_sel), .in_stall_n(stall_n),
      .in_take_new_pc(ex_take_new_pc),
      .out_rd_data_2(m_rd_data_2), .out_alu_out(m_alu_out), .out_sext_imm(m_sext_imm),
      .out_pc_sext_imm(m_pc_sext_imm), .out_reg_sext_imm(m_reg_sext_imm),
      .out_pc_inc(m_pc_inc), .out_alu_ofl(m_alu_ofl), .out_alu_zero(m_alu_zero),
      .out_alu_ltz(m_alu_ltz), .out_alu_lteq(m_alu_lteq), .out_pc_src(m_pc_src),
      .out_set_sel(m_set_sel), .out_mem_wr_en(m_mem_wr_en), .out_mem_en(m_mem_en),
      .out_wr_reg(m_wr_reg), .out_wr_sel(m_wr_sel), .out_stall_n(m_stall_n),
      .out_take_new_pc(m_take_new_pc)
   );

   mem_stage u_mem (
      .clk, .arst_n,
      .rd_data_2(m_rd_data_2), .alu_out(m_alu_out), .sext_imm(m_sext_imm),
      .pc_sext_imm(m_pc_sext_imm), .reg_sext_imm(m_reg_sext_imm), .pc_inc(m_pc_inc),
      .alu_ofl(m_alu_ofl), .alu_zero(m_alu_zero), .alu_ltz(m_alu_ltz),
      .alu_lteq(m_alu_lteq), .pc_src(m_pc_src), .set_sel(m_set_sel),
      .mem_wr_en(m_mem_wr_en), .mem_en(m_mem_en), .wr_reg(m_wr_reg), .wr_sel(m_wr_sel),
      .stall_n(m_stall_n), .take_new_pc(m_take_new_pc),
      .wb_en, .wb_reg, .wb_data, .redirect_en, .redirect_pc
   );

endmodule

/* verilog/cpu_pkg.sv */
`include "cpu_settings.svh"

package cpu_pkg;

   typedef logic [`CPU_DATA_W-1:0]     word_t;
   typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

   typedef enum logic [2:0] {
      alu_add    = 3'd0,
      alu_sub    = 3'd1,
      alu_and    = 3'd2,
      alu_or     = 3'd3,
      alu_xor    = 3'd4,
      alu_sll    = 3'd5,
      alu_srl    = 3'd6,
      alu_pass_b = 3'd7
   } alu_op_t;

   typedef enum logic [1:0] {
      set_seq = 2'd0,   // a == b
      set_slt = 2'd1,   // a < b, signed
      set_sle = 2'd2,   // a <= b, signed
      set_sco = 2'd3    // carry out of a + b
   } set_sel_t;

   typedef enum logic [2:0] {
      wb_alu    = 3'd0,
      wb_mem    = 3'd1,
      wb_set    = 3'd2,
      wb_imm    = 3'd3,
      wb_pc_inc = 3'd4,
      wb_none   = 3'd7
   } wr_sel_t;

endpackage

/* verilog/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// machine word, also the width of every address and immediate
`define CPU_DATA_W 16

// eight architectural registers
`define CPU_REG_ADDR_W 3

// data memory words, addressed by the low alu_out bits
`define CPU_DMEM_DEPTH 256

`endif

/* verilog/ex_mem.sv */
`timescale 1ns/10ps

module ex_mem import cpu_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  word_t     in_rd_data_2,
   input  word_t     in_alu_out,
   input  word_t     in_sext_imm,
   input  word_t     in_pc_sext_imm,
   input  word_t     in_reg_sext_imm,
   input  word_t     in_pc_inc,
   input  logic      in_alu_ofl,
   input  logic      in_alu_zero,
   input  logic      in_alu_ltz,
   input  logic      in_alu_lteq,
   input  logic      in_pc_src,
   input  set_sel_t  in_set_sel,
   input  logic      in_mem_wr_en,
   input  logic      in_mem_en,
   input  reg_addr_t in_wr_reg,
   input  wr_sel_t   in_wr_sel,
   input  logic      in_stall_n,       // low when the previous stage stalls
   input  logic      in_take_new_pc,   // taken branch or jump from execute
   output word_t     out_rd_data_2,
   output word_t     out_alu_out,
   output word_t     out_sext_imm,
   output word_t     out_pc_sext_imm,
   output word_t     out_reg_sext_imm,
   output word_t     out_pc_inc,
   output logic      out_alu_ofl,
   output logic      out_alu_zero,
   output logic      out_alu_ltz,
   output logic      out_alu_lteq,
   output logic      out_pc_src,
   output set_sel_t  out_set_sel,
   output logic      out_mem_wr_en,
   output logic      out_mem_en,
   output reg_addr_t out_wr_reg,
   output wr_sel_t   out_wr_sel,
   output logic      out_stall_n,
   output logic      out_take_new_pc
);

   logic stall_q_n;
   logic redir_ld;

   // a taken transfer overrides the upstream stall and holds the slot
   assign stall_q_n = in_take_new_pc ? 1'b0 : in_stall_n;

   // redirect target fields must still capture the transfer's targets
   assign redir_ld = stall_q_n | in_take_new_pc;

   pipe_reg u_rd_data_2 (.clk, .arst_n, .load(stall_q_n), .d(in_rd_data_2), .q(out_rd_data_2));
   pipe_reg u_alu_out (.clk, .arst_n, .load(stall_q_n), .d(in_alu_out), .q(out_alu_out));
   pipe_reg u_sext_imm (.clk, .arst_n, .load(stall_q_n), .d(in_sext_imm), .q(out_sext_imm));
   pipe_reg u_pc_inc (.clk, .arst_n, .load(stall_q_n), .d(in_pc_inc), .q(out_pc_inc));
   pipe_reg u_pc_sext (.clk, .arst_n, .load(redir_ld), .d(in_pc_sext_imm), .q(out_pc_sext_imm));
   pipe_reg u_reg_sext (.clk, .arst_n, .load(redir_ld), .d(in_reg_sext_imm), .q(out_reg_sext_imm));

   pipe_reg #(.payload_t(logic)) u_pc_src
      (.clk, .arst_n, .load(redir_ld), .d(in_pc_src), .q(out_pc_src));
   pipe_reg #(.payload_t(logic)) u_alu_ofl
      (.clk, .arst_n, .load(stall_q_n), .d(in_alu_ofl), .q(out_alu_ofl));
   pipe_reg #(.payload_t(logic)) u_alu_zero
      (.clk, .arst_n, .load(stall_q_n), .d(in_alu_zero), .q(out_alu_zero));
   pipe_reg #(.payload_t(logic)) u_alu_ltz
      (.clk, .arst_n, .load(stall_q_n), .d(in_alu_ltz), .q(out_alu_ltz));
   pipe_reg #(.payload_t(logic)) u_alu_lteq
      (.clk, .arst_n, .load(stall_q_n), .d(in_alu_lteq), .q(out_alu_lteq));
   pipe_reg #(.payload_t(logic)) u_mem_wr_en
      (.clk, .arst_n, .load(stall_q_n), .d(in_mem_wr_en), .q(out_mem_wr_en));
   pipe_reg #(.payload_t(logic)) u_mem_en
      (.clk, .arst_n, .load(stall_q_n), .d(in_mem_en), .q(out_mem_en));
   pipe_reg #(.payload_t(set_sel_t)) u_set_sel
      (.clk, .arst_n, .load(stall_q_n), .d(in_set_sel), .q(out_set_sel));
   pipe_reg #(.payload_t(reg_addr_t)) u_wr_reg
      (.clk, .arst_n, .load(stall_q_n), .d(in_wr_reg), .q(out_wr_reg));
   pipe_reg #(.payload_t(wr_sel_t), .RST_VAL(wb_none)) u_wr_sel
      (.clk, .arst_n, .load(stall_q_n), .d(in_wr_sel), .q(out_wr_sel));

   // slot status flags load every cycle
   pipe_reg #(.payload_t(logic)) u_stall_n
      (.clk, .arst_n, .load(1'b1), .d(stall_q_n), .q(out_stall_n));
   pipe_reg #(.payload_t(logic)) u_take_new_pc
      (.clk, .arst_n, .load(1'b1), .d(in_take_new_pc), .q(out_take_new_pc));

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage import cpu_pkg::*; (
   input  word_t    rd_data_1,
   input  word_t    rd_data_2,
   input  word_t    sext_imm,
   input  word_t    pc_inc,
   input  alu_op_t  alu_op,
   input  logic     alu_src_imm,
   input  set_sel_t set_sel,
   input  logic     branch_en,
   input  logic     branch_on_zero,
   input  logic     jump_reg,
   output word_t    alu_out,
   output word_t    pc_sext_imm,
   output word_t    reg_sext_imm,
   output logic     alu_ofl,
   output logic     alu_zero,
   output logic     alu_ltz,
   output logic     alu_lteq,
   output logic     pc_src,
   output logic     take_new_pc
);

   localparam int W   = $bits(word_t);
   localparam int SHW = $clog2(W);

   word_t      op_b;
   logic [W:0] add_full;   // top bit is the carry out
   word_t      sub_res;
   logic       add_ofl;
   logic       sub_ofl;
   logic       reg_cond;

   assign op_b     = alu_src_imm ? sext_imm : rd_data_2;
   assign add_full = {1'b0, rd_data_1} + {1'b0, op_b};
   assign sub_res  = rd_data_1 - op_b;

   // signed overflow from the operand and result sign bits
   assign add_ofl = (rd_data_1[W-1] == op_b[W-1]) && (add_full[W-1] != rd_data_1[W-1]);
   assign sub_ofl = (rd_data_1[W-1] != op_b[W-1]) && (sub_res[W-1] != rd_data_1[W-1]);

   always_comb begin
      case (alu_op)
         alu_add: alu_out = add_full[W-1:0];
         alu_sub: alu_out = sub_res;
         alu_and: alu_out = rd_data_1 & op_b;
         alu_or:  alu_out = rd_data_1 | op_b;
         alu_xor: alu_out = rd_data_1 ^ op_b;
         alu_sll: alu_out = rd_data_1 << op_b[SHW-1:0];
         alu_srl: alu_out = rd_data_1 >> op_b[SHW-1:0];
         default: alu_out = op_b;   // pass_b
      endcase
   end

   // sco reuses the overflow flag to carry the add carry out
   always_comb begin
      if (set_sel == set_sco)
         alu_ofl = add_full[W];
      else if (alu_op == alu_add)
         alu_ofl = add_ofl;
      else if (alu_op == alu_sub)
         alu_ofl = sub_ofl;
      else
         alu_ofl = 1'b0;
   end

   // compare flags always come from a - b
   assign alu_zero = (sub_res == '0);
   assign alu_ltz  = sub_res[W-1] ^ sub_ofl;   // true sign of a - b
   assign alu_lteq = alu_ltz | alu_zero;

   assign pc_sext_imm  = pc_inc + sext_imm;      // branch target
   assign reg_sext_imm = rd_data_1 + sext_imm;   // register jump target

   assign reg_cond    = branch_on_zero ? (rd_data_1 == '0) : (rd_data_1 != '0);
   assign take_new_pc = jump_reg | (branch_en & reg_cond);
   assign pc_src      = branch_en & ~jump_reg;   // jump wins if both set

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module mem_stage import cpu_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  word_t     rd_data_2,      // store data
   input  word_t     alu_out,        // memory address or alu result
   input  word_t     sext_imm,
   input  word_t     pc_sext_imm,
   input  word_t     reg_sext_imm,
   input  word_t     pc_inc,
   input  logic      alu_ofl,
   input  logic      alu_zero,
   input  logic      alu_ltz,
   input  logic      alu_lteq,
   input  logic      pc_src,
   input  set_sel_t  set_sel,
   input  logic      mem_wr_en,
   input  logic      mem_en,
   input  reg_addr_t wr_reg,
   input  wr_sel_t   wr_sel,
   input  logic      stall_n,        // slot valid flag from ex_mem
   input  logic      take_new_pc,    // registered redirect for the slot
   output logic      wb_en,
   output reg_addr_t wb_reg,
   output word_t     wb_data,
   output logic      redirect_en,
   output word_t     redirect_pc
);

   localparam int AW = $clog2(`CPU_DMEM_DEPTH);

   word_t         dmem [`CPU_DMEM_DEPTH];
   logic [AW-1:0] addr;
   logic          mem_we;
   word_t         rd_word;
   logic          set_bit;

   assign addr   = alu_out[AW-1:0];
   assign mem_we = mem_wr_en & mem_en & stall_n;   // held or flushed slot never stores

   always_ff @(posedge clk) begin
      if (arst_n && mem_we)
         dmem[addr] <= rd_data_2;
   end

   assign rd_word = dmem[addr];   // combinational read

   always_comb begin
      case (set_sel)
         set_seq: set_bit = alu_zero;
         set_slt: set_bit = alu_ltz;
         set_sle: set_bit = alu_lteq;
         default: set_bit = alu_ofl;   // sco, carry out
      endcase
   end

   always_comb begin
      case (wr_sel)
         wb_alu:    wb_data = alu_out;
         wb_mem:    wb_data = rd_word;
         wb_set:    wb_data = word_t'(set_bit);
         wb_imm:    wb_data = sext_imm;
         wb_pc_inc: wb_data = pc_inc;
         default:   wb_data = '0;
      endcase
   end

   assign wb_en  = stall_n & (wr_sel != wb_none);
   assign wb_reg = wr_reg;

   assign redirect_en = take_new_pc;
   assign redirect_pc = pc_src ? pc_sext_imm : reg_sext_imm;

endmodule

/* verilog/pipe_reg.sv */
`timescale 1ns/10ps

module pipe_reg import cpu_pkg::*; #(
   parameter type      payload_t = word_t,
   parameter payload_t RST_VAL   = payload_t'(0)
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     load,
   input  payload_t d,
   output payload_t q
);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         q <= RST_VAL;
      else if (load)
         q <= d;   // otherwise hold
   end

endmodule
